/* all.f */
+incdir+include
logic/decode_pkg.sv
logic/decode_ctrl_if.sv
logic/register_file.sv
logic/opcode_decoder.sv
logic/branch_resolver.sv
logic/id_ex_register.sv
logic/instruction_decode.sv
sim/tb_instruction_decode.sv

/* Makefile */
TOP = tb_instruction_decode

sim:
	verilator --binary --assert --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* include/tb_decode_model.svh */
// Expected {EX, MEM, WB} frames of one instruction word
function automatic logic [19:0] expect_frames(input logic [31:0] w);
   logic [5:0] op;
   logic [5:0] fn;
   logic [1:0] size;
   logic [3:0] alu;
   logic [2:0] ex_bits;
   logic [4:0] mem;
   logic [4:0] dest;
   logic [2:0] wb_bits;
   op      = w[31:26];
   fn      = w[5:0];
   // Byte 0, half 1, word 2
   size    = (op[1:0] == 2'b11) ? 2'b10 : op[1:0];
   alu     = decode_pkg::ALU_ADD;
   ex_bits = 3'b100;
   mem     = 5'b00000;
   dest    = w[20:16];
   wb_bits = 3'b110;
   case (op)
      decode_pkg::R_INST: begin
         // Only SLL, SRL and SRA shift by the shamt field
         ex_bits = {2'b00, fn[5:2] == 4'b0000};
         dest    = w[15:11];
         wb_bits = {2'b11, fn == decode_pkg::FUNC_JALR};
         case (fn)
            decode_pkg::FUNC_SLL, decode_pkg::FUNC_SLLV: alu = decode_pkg::ALU_SLL;
            decode_pkg::FUNC_SRL, decode_pkg::FUNC_SRLV: alu = decode_pkg::ALU_SRL;
            decode_pkg::FUNC_SRA, decode_pkg::FUNC_SRAV: alu = decode_pkg::ALU_SRA;
            decode_pkg::FUNC_SUBU: alu = decode_pkg::ALU_SUB;
            decode_pkg::FUNC_AND:  alu = decode_pkg::ALU_AND;
            decode_pkg::FUNC_OR:   alu = decode_pkg::ALU_OR;
            decode_pkg::FUNC_XOR:  alu = decode_pkg::ALU_XOR;
            decode_pkg::FUNC_NOR:  alu = decode_pkg::ALU_NOR;
            decode_pkg::FUNC_SLT:  alu = decode_pkg::ALU_SLT;
            default: ;
         endcase
      end
      decode_pkg::LB, decode_pkg::LH, decode_pkg::LW,
      decode_pkg::LBU, decode_pkg::LHU, decode_pkg::LWU: begin
         mem     = {2'b10, op[2], size};
         wb_bits = 3'b100;
      end
      decode_pkg::SB, decode_pkg::SH, decode_pkg::SW: begin
         mem     = {2'b01, 1'b0, size};
         wb_bits = 3'b000;
      end
      decode_pkg::SLTI: alu = decode_pkg::ALU_SLT;
      decode_pkg::ANDI: alu = decode_pkg::ALU_AND;
      decode_pkg::ORI:  alu = decode_pkg::ALU_OR;
      decode_pkg::XORI: alu = decode_pkg::ALU_XOR;
      decode_pkg::LUI:  alu = decode_pkg::ALU_LUI;
      decode_pkg::BEQ, decode_pkg::BNE: wb_bits = 3'b000;
      decode_pkg::J: begin
         ex_bits = 3'b000;
         dest    = w[15:11];
         wb_bits = 3'b000;
      end
      decode_pkg::JAL: begin
         ex_bits = 3'b000;
         dest    = decode_pkg::RA_ADDR;
         wb_bits = 3'b101;
      end
      default: ;
   endcase
   // ANDI ORI XORI LUI take an unsigned immediate
   if (op[5:2] == 4'b0011) begin
      ex_bits = 3'b110;
   end
   return {alu, ex_bits, mem, dest, wb_bits[2] & (dest != 5'd0), wb_bits[1:0]};
endfunction

// Expected {branch taken, jump rs, jump immediate, flush}
function automatic logic [3:0] expect_redirect(input logic [31:0] w,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
   logic taken;
   logic jump_rs;
   logic jump_inm;
   taken    = (w[31:26] == decode_pkg::BEQ && a == b)
              || (w[31:26] == decode_pkg::BNE && a != b);
   jump_rs  = w[31:26] == decode_pkg::R_INST
              && (w[5:0] == decode_pkg::FUNC_JR || w[5:0] == decode_pkg::FUNC_JALR);
   jump_inm = w[31:26] == decode_pkg::J || w[31:26] == decode_pkg::JAL;
   return {taken, jump_rs, jump_inm, taken | jump_rs | jump_inm};
endfunction

/* sim/tb_instruction_decode.sv */
module tb_instruction_decode;

   localparam int NUM_CYCLES = 1200;
   localparam int MAX_CYCLES = NUM_CYCLES + NUM_CYCLES / 2 + 200;

   localparam logic [5:0] OPCODES [20] = '{
      decode_pkg::R_INST, decode_pkg::LB, decode_pkg::LH, decode_pkg::LW, decode_pkg::LBU,
      decode_pkg::LHU, decode_pkg::LWU, decode_pkg::SB, decode_pkg::SH, decode_pkg::SW,
      decode_pkg::ADDI, decode_pkg::ANDI, decode_pkg::ORI, decode_pkg::XORI, decode_pkg::LUI,
      decode_pkg::SLTI, decode_pkg::BEQ, decode_pkg::BNE, decode_pkg::J, decode_pkg::JAL
   };
   localparam logic [5:0] FUNCS [15] = '{
      decode_pkg::FUNC_SLL, decode_pkg::FUNC_SRL, decode_pkg::FUNC_SRA, decode_pkg::FUNC_SLLV,
      decode_pkg::FUNC_SRLV, decode_pkg::FUNC_SRAV, decode_pkg::FUNC_ADDU, decode_pkg::FUNC_SUBU,
      decode_pkg::FUNC_AND, decode_pkg::FUNC_OR, decode_pkg::FUNC_XOR, decode_pkg::FUNC_NOR,
      decode_pkg::FUNC_SLT, decode_pkg::FUNC_JR, decode_pkg::FUNC_JALR
   };

   logic                          i_clk;
   logic                          i_rst;
   logic                          i_valid;
   logic [31:0]                   i_instruction;
   logic [31:0]                   i_pc;
   logic                          i_regfile_we;
   logic [4:0]                    i_regfile_addr;
   logic [31:0]                   i_regfile_data;
   logic [decode_pkg::NB_EX-1:0]  o_ex_ctrl;
   logic [decode_pkg::NB_MEM-1:0] o_mem_ctrl;
   logic [decode_pkg::NB_WB-1:0]  o_wb_ctrl;
   logic [31:0]                   o_pc, o_a, o_b, o_jump_rs_addr;
   logic [15:0]                   o_inm;
   logic [4:0]                    o_shamt;
   logic [25:0]                   o_jump_inm_addr;
   logic                          o_nop, o_branch, o_branch_result, o_jump_rs;
   logic                          o_jump_inm, o_rinst, o_store;

   logic [31:0] lfsr;
   logic [31:0] shadow [32];
   logic [31:0] rs_val;
   logic [31:0] rt_val;
   logic [3:0]  redirect;
   logic [5:0]  exp_flags;
   logic [19:0] exp_frames;
   logic [31:0] exp_a;
   logic [31:0] exp_b;
   logic [31:0] exp_pc;
   logic        exp_nop;
   logic [15:0] exp_inm;
   logic [4:0]  exp_shamt;
   logic        imm_loaded = 1'b0;
   int          cycles = 0;

   instruction_decode dut0 (.*);

   `include "tb_decode_model.svh"

   // Shadow read with the same-cycle write-back visible
   assign rs_val = (i_valid && i_regfile_we && i_regfile_addr == i_instruction[25:21])
                 ? i_regfile_data : shadow[i_instruction[25:21]];
   assign rt_val = (i_valid && i_regfile_we && i_regfile_addr == i_instruction[20:16])
                 ? i_regfile_data : shadow[i_instruction[20:16]];

   assign redirect  = expect_redirect(i_instruction, rs_val, rt_val);
   assign exp_flags = {
      i_instruction[31:26] == decode_pkg::BEQ || i_instruction[31:26] == decode_pkg::BNE,
      redirect[3:1],
      i_instruction[31:26] == decode_pkg::R_INST,
      i_instruction[31:26] inside {decode_pkg::SB, decode_pkg::SH, decode_pkg::SW}
   };

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   // Galois LFSR, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] value;
      value = '0;
      for (int k = 0; k < n; k++) begin
         value = {value[30:0], lfsr[0]};
         lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return value;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "check %s failed", name);
   endtask

   task automatic drive_cycle();
      logic [31:0] word;
      logic [4:0]  op_sel;
      logic [3:0]  fn_sel;
      word        = take_bits(32);
      op_sel      = 5'(take_bits(5) % 20);
      fn_sel      = 4'(take_bits(4) % 15);
      word[31:26] = OPCODES[op_sel];
      // Registers 0 to 7 so operands and writes collide often
      word[25:21] = 5'(take_bits(3));
      word[20:16] = 5'(take_bits(3));
      if (word[31:26] == decode_pkg::R_INST) begin
         word[15:11] = 5'(take_bits(3));
         word[5:0]   = FUNCS[fn_sel];
      end
      i_instruction  <= word;
      i_pc           <= take_bits(32);
      i_valid        <= take_bits(3) != 0;
      i_regfile_we   <= take_bits(1) != 0;
      i_regfile_addr <= 5'(take_bits(3));
      i_regfile_data <= (take_bits(1) != 0) ? take_bits(32) : take_bits(2);
   endtask

   //////////////////////////////////////////////////
   // Expected stage register and register file
   //////////////////////////////////////////////////

   always @(posedge i_clk) begin
      if (i_rst) begin
         for (int k = 0; k < 32; k++) begin
            shadow[k] <= '0;
         end
         exp_frames <= '0;
         exp_a      <= '0;
         exp_b      <= '0;
         exp_pc     <= '0;
         exp_nop    <= 1'b0;
      end else if (i_valid) begin
         exp_frames <= expect_frames(i_instruction);
         exp_a      <= rs_val;
         exp_b      <= rt_val;
         exp_pc     <= i_pc;
         exp_nop    <= redirect[0];
         if (i_regfile_we) begin
            shadow[i_regfile_addr] <= i_regfile_data;
         end
      end
   end

   // Immediate and shift amount load on every valid cycle
   always @(posedge i_clk) begin
      if (i_valid) begin
         exp_inm    <= i_instruction[15:0];
         exp_shamt  <= i_instruction[10:6];
         imm_loaded <= 1'b1;
      end
   end

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Run did not finish within %0d cycles", MAX_CYCLES);
         $display("TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   //////////////////////////////////////////////////
   // Checks at the falling edge
   //////////////////////////////////////////////////

   frames_check: assert property (@(negedge i_clk) disable iff (i_rst)
      {o_ex_ctrl, o_mem_ctrl, o_wb_ctrl} == exp_frames)
      else report_mismatch("frames", 32'(exp_frames), 32'({o_ex_ctrl, o_mem_ctrl, o_wb_ctrl}));
   operand_a_check: assert property (@(negedge i_clk) disable iff (i_rst) o_a == exp_a)
      else report_mismatch("operand_a", exp_a, o_a);
   operand_b_check: assert property (@(negedge i_clk) disable iff (i_rst) o_b == exp_b)
      else report_mismatch("operand_b", exp_b, o_b);
   pc_check: assert property (@(negedge i_clk) disable iff (i_rst) o_pc == exp_pc)
      else report_mismatch("pc", exp_pc, o_pc);
   nop_check: assert property (@(negedge i_clk) disable iff (i_rst) o_nop == exp_nop)
      else report_mismatch("nop", 32'(exp_nop), 32'(o_nop));
   inm_check: assert property (@(negedge i_clk) disable iff (i_rst || !imm_loaded)
      o_inm == exp_inm)
      else report_mismatch("inm", 32'(exp_inm), 32'(o_inm));
   shamt_check: assert property (@(negedge i_clk) disable iff (i_rst || !imm_loaded)
      o_shamt == exp_shamt)
      else report_mismatch("shamt", 32'(exp_shamt), 32'(o_shamt));
   // Same-cycle branch, jump, R-type and store flags
   redirect_check: assert property (@(negedge i_clk) disable iff (i_rst)
      {o_branch, o_branch_result, o_jump_rs, o_jump_inm, o_rinst, o_store} == exp_flags)
      else report_mismatch("redirect", 32'(exp_flags),
                           32'({o_branch, o_branch_result, o_jump_rs, o_jump_inm, o_rinst,
                                o_store}));
   jump_rs_addr_check: assert property (@(negedge i_clk) disable iff (i_rst)
      o_jump_rs_addr == rs_val)
      else report_mismatch("jump_rs_addr", rs_val, o_jump_rs_addr);
   jump_inm_addr_check: assert property (@(negedge i_clk) disable iff (i_rst)
      o_jump_inm_addr == i_instruction[25:0])
      else report_mismatch("jump_inm_addr", 32'(i_instruction[25:0]), 32'(o_jump_inm_addr));

   initial begin
      lfsr = 32'h71730a79;
      i_rst          <= 1'b1;
      i_valid        <= 1'b0;
      i_instruction  <= '0;
      i_pc           <= '0;
      i_regfile_we   <= 1'b0;
      i_regfile_addr <= '0;
      i_regfile_data <= '0;
      repeat (8) @(posedge i_clk);
      i_rst <= 1'b0;
      repeat (NUM_CYCLES) begin
         drive_cycle();
         @(posedge i_clk);
      end
      // Let the last captured instruction reach its checks
      repeat (2) @(posedge i_clk);
      $display("TESTS PASSED");
      $finish;
   end

endmodule

/* logic/instruction_decode.sv */
module instruction_decode (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic                          i_valid,
   input  logic [31:0]                   i_instruction,
   input  logic [31:0]                   i_pc,
   input  logic                          i_regfile_we,
   input  logic [4:0]                    i_regfile_addr,
   input  logic [31:0]                   i_regfile_data,
   output logic [decode_pkg::NB_EX-1:0]  o_ex_ctrl,
   output logic [decode_pkg::NB_MEM-1:0] o_mem_ctrl,
   output logic [decode_pkg::NB_WB-1:0]  o_wb_ctrl,
   output logic [31:0]                   o_pc,
   output logic [31:0]                   o_a,
   output logic [31:0]                   o_b,
   output logic [15:0]                   o_inm,
   output logic [4:0]                    o_shamt,
   output logic                          o_nop,
   output logic                          o_branch,
   output logic                          o_branch_result,
   output logic                          o_jump_rs,
   output logic [31:0]                   o_jump_rs_addr,
   output logic                          o_jump_inm,
   output logic [25:0]                   o_jump_inm_addr,
   output logic                          o_rinst,
   output logic                          o_store
);

   decode_pkg::instr_u instr;
   logic               wr_en;
   logic [31:0]        rs_data;
   logic [31:0]        rt_data;
   logic               flush;

   decode_ctrl_if ctrl_if ();

   assign instr = i_instruction;

   // Write-back only lands with a valid cycle
   assign wr_en = i_regfile_we & i_valid;

   register_file u_regfile (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_we      (wr_en),
      .i_waddr   (i_regfile_addr),
      .i_wdata   (i_regfile_data),
      .i_instr   (instr),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   opcode_decoder u_decoder (
      .i_instr (instr),
      .ctrl    (ctrl_if.decoder)
   );

   branch_resolver u_resolver (
      .i_rs_data       (rs_data),
      .i_rt_data       (rt_data),
      .ctrl            (ctrl_if.resolver),
      .o_branch        (o_branch),
      .o_branch_result (o_branch_result),
      .o_jump_rs       (o_jump_rs),
      .o_jump_inm      (o_jump_inm),
      .o_flush         (flush)
   );

   id_ex_register u_id_ex (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_valid    (i_valid),
      .i_instr    (instr),
      .i_pc       (i_pc),
      .i_rs_data  (rs_data),
      .i_rt_data  (rt_data),
      .i_flush    (flush),
      .ctrl       (ctrl_if.stage),
      .o_ex_ctrl  (o_ex_ctrl),
      .o_mem_ctrl (o_mem_ctrl),
      .o_wb_ctrl  (o_wb_ctrl),
      .o_pc       (o_pc),
      .o_a        (o_a),
      .o_b        (o_b),
      .o_inm      (o_inm),
      .o_shamt    (o_shamt),
      .o_nop      (o_nop)
   );

   assign o_jump_rs_addr  = rs_data;
   assign o_jump_inm_addr = instr.j.target26;
   assign o_rinst         = ctrl_if.use_func_table;
   assign o_store         = ctrl_if.mem_we;

endmodule

/* logic/id_ex_register.sv */
module id_ex_register (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic                          i_valid,
   input  decode_pkg::instr_u            i_instr,
   input  logic [31:0]                   i_pc,
   input  logic [31:0]                   i_rs_data,
   input  logic [31:0]                   i_rt_data,
   input  logic                          i_flush,
   decode_ctrl_if.stage                  ctrl,
   output logic [decode_pkg::NB_EX-1:0]  o_ex_ctrl,
   output logic [decode_pkg::NB_MEM-1:0] o_mem_ctrl,
   output logic [decode_pkg::NB_WB-1:0]  o_wb_ctrl,
   output logic [31:0]                   o_pc,
   output logic [31:0]                   o_a,
   output logic [31:0]                   o_b,
   output logic [15:0]                   o_inm,
   output logic [4:0]                    o_shamt,
   output logic                          o_nop
);

   logic [4:0]                    dest;
   logic [decode_pkg::NB_EX-1:0]  ex_frame;
   logic [decode_pkg::NB_MEM-1:0] mem_frame;
   logic [decode_pkg::NB_WB-1:0]  wb_frame;

   // Link, then immediate format, then rd
   assign dest = ctrl.to_ra ? decode_pkg::RA_ADDR
               : ctrl.b_i   ? i_instr.r.rt
               :              i_instr.r.rd;

   assign ex_frame  = {ctrl.alu_code, ctrl.b_i, ctrl.s_u_ex, ctrl.use_shamt};
   assign mem_frame = {ctrl.mem_re, ctrl.mem_we, ctrl.s_u_mem, ctrl.dsize};

   // No write to register zero
   assign wb_frame = {dest, ctrl.reg_we & (|dest), ctrl.mem_alu, ctrl.data_pc};

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex_ctrl  <= '0;
         o_mem_ctrl <= '0;
         o_wb_ctrl  <= '0;
         o_nop      <= 1'b0;
         o_a        <= '0;
         o_b        <= '0;
         o_pc       <= '0;
      end else if (i_valid) begin
         o_ex_ctrl  <= ex_frame;
         o_mem_ctrl <= mem_frame;
         o_wb_ctrl  <= wb_frame;
         o_nop      <= i_flush;
         o_a        <= i_rs_data;
         o_b        <= i_rt_data;
         o_pc       <= i_pc;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         o_inm   <= i_instr.i.imm16;
         o_shamt <= i_instr.r.shamt;
      end
   end

endmodule

/* logic/branch_resolver.sv */
module branch_resolver (
   input  logic [31:0]     i_rs_data,
   input  logic [31:0]     i_rt_data,
   decode_ctrl_if.resolver ctrl,
   output logic            o_branch,
   output logic            o_branch_result,
   output logic            o_jump_rs,
   output logic            o_jump_inm,
   output logic            o_flush
);

   logic equal;
   logic taken;

   assign equal = (i_rs_data == i_rt_data);

   // BNE takes the branch on a mismatch
   assign taken = ctrl.is_branch & (equal ^ ctrl.bne);

   assign o_branch        = ctrl.is_branch;
   assign o_branch_result = taken;
   assign o_jump_rs       = ctrl.jump_rs;
   assign o_jump_inm      = ctrl.jump_inm;

   // Any redirect squashes the next fetch
   assign o_flush = taken | ctrl.jump_rs | ctrl.jump_inm;

endmodule

/* logic/opcode_decoder.sv */
module opcode_decoder (
   input  decode_pkg::instr_u i_instr,
   decode_ctrl_if.decoder     ctrl
);

   logic [5:0] opcode;
   logic [1:0] size_code;
   logic [3:0] func_alu;
   logic       func_shamt;
   logic       func_link;
   logic       func_jump;

   assign opcode = i_instr.i.opcode;

   // Byte, half or word from the low opcode bits
   assign size_code = {opcode[1], opcode[0] & ~opcode[1]};

   //////////////////////////////////////////////////
   // Function table
   //////////////////////////////////////////////////

   always_comb begin
      func_alu   = decode_pkg::ALU_ADD;
      func_shamt = 1'b0;
      func_link  = 1'b0;
      func_jump  = 1'b0;
      case (i_instr.r.func)
         decode_pkg::FUNC_SLL: begin
            func_alu   = decode_pkg::ALU_SLL;
            func_shamt = 1'b1;
         end
         decode_pkg::FUNC_SRL: begin
            func_alu   = decode_pkg::ALU_SRL;
            func_shamt = 1'b1;
         end
         decode_pkg::FUNC_SRA: begin
            func_alu   = decode_pkg::ALU_SRA;
            func_shamt = 1'b1;
         end
         decode_pkg::FUNC_SLLV: func_alu = decode_pkg::ALU_SLL;
         decode_pkg::FUNC_SRLV: func_alu = decode_pkg::ALU_SRL;
         decode_pkg::FUNC_SRAV: func_alu = decode_pkg::ALU_SRA;
         decode_pkg::FUNC_ADDU: func_alu = decode_pkg::ALU_ADD;
         decode_pkg::FUNC_SUBU: func_alu = decode_pkg::ALU_SUB;
         decode_pkg::FUNC_AND:  func_alu = decode_pkg::ALU_AND;
         decode_pkg::FUNC_OR:   func_alu = decode_pkg::ALU_OR;
         decode_pkg::FUNC_XOR:  func_alu = decode_pkg::ALU_XOR;
         decode_pkg::FUNC_NOR:  func_alu = decode_pkg::ALU_NOR;
         decode_pkg::FUNC_SLT:  func_alu = decode_pkg::ALU_SLT;
         decode_pkg::FUNC_JR:   func_jump = 1'b1;
         decode_pkg::FUNC_JALR: begin
            func_jump = 1'b1;
            func_link = 1'b1;
         end
         default: ;
      endcase
   end

   //////////////////////////////////////////////////
   // Opcode table
   //////////////////////////////////////////////////

   always_comb begin
      ctrl.use_func_table = 1'b0;
      ctrl.alu_code       = decode_pkg::ALU_ADD;
      ctrl.b_i            = 1'b0;
      ctrl.s_u_ex         = 1'b0;
      ctrl.use_shamt      = 1'b0;
      ctrl.mem_re         = 1'b0;
      ctrl.mem_we         = 1'b0;
      ctrl.s_u_mem        = 1'b0;
      ctrl.dsize          = 2'b00;
      ctrl.reg_we         = 1'b0;
      ctrl.mem_alu        = 1'b0;
      ctrl.data_pc        = 1'b0;
      ctrl.to_ra          = 1'b0;
      ctrl.is_branch      = 1'b0;
      ctrl.bne            = 1'b0;
      ctrl.jump_inm       = 1'b0;
      ctrl.jump_rs        = 1'b0;
      case (opcode)
         decode_pkg::R_INST: begin
            ctrl.use_func_table = 1'b1;
            ctrl.alu_code       = func_alu;
            ctrl.use_shamt      = func_shamt;
            ctrl.data_pc        = func_link;
            ctrl.jump_rs        = func_jump;
            ctrl.reg_we         = 1'b1;
            ctrl.mem_alu        = 1'b1;
         end
         decode_pkg::LB, decode_pkg::LH, decode_pkg::LW,
         decode_pkg::LBU, decode_pkg::LHU, decode_pkg::LWU: begin
            ctrl.b_i     = 1'b1;
            ctrl.mem_re  = 1'b1;
            ctrl.s_u_mem = opcode[2];
            ctrl.dsize   = size_code;
            ctrl.reg_we  = 1'b1;
         end
         decode_pkg::SB, decode_pkg::SH, decode_pkg::SW: begin
            ctrl.b_i    = 1'b1;
            ctrl.mem_we = 1'b1;
            ctrl.dsize  = size_code;
         end
         decode_pkg::ADDI, decode_pkg::SLTI: begin
            ctrl.alu_code = (opcode == decode_pkg::SLTI) ? decode_pkg::ALU_SLT
                                                         : decode_pkg::ALU_ADD;
            ctrl.b_i      = 1'b1;
            ctrl.reg_we   = 1'b1;
            ctrl.mem_alu  = 1'b1;
         end
         decode_pkg::ANDI, decode_pkg::ORI, decode_pkg::XORI, decode_pkg::LUI: begin
            case (opcode)
               decode_pkg::ANDI: ctrl.alu_code = decode_pkg::ALU_AND;
               decode_pkg::ORI:  ctrl.alu_code = decode_pkg::ALU_OR;
               decode_pkg::XORI: ctrl.alu_code = decode_pkg::ALU_XOR;
               default:          ctrl.alu_code = decode_pkg::ALU_LUI;
            endcase
            // Logical immediates are zero extended
            ctrl.s_u_ex  = 1'b1;
            ctrl.b_i     = 1'b1;
            ctrl.reg_we  = 1'b1;
            ctrl.mem_alu = 1'b1;
         end
         decode_pkg::BEQ, decode_pkg::BNE: begin
            ctrl.b_i       = 1'b1;
            ctrl.is_branch = 1'b1;
            ctrl.bne       = (opcode == decode_pkg::BNE);
         end
         decode_pkg::J: ctrl.jump_inm = 1'b1;
         decode_pkg::JAL: begin
            ctrl.jump_inm = 1'b1;
            ctrl.to_ra    = 1'b1;
            ctrl.reg_we   = 1'b1;
            ctrl.data_pc  = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

/* logic/register_file.sv */
module register_file (
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_we,
   input  logic [4:0]         i_waddr,
   input  logic [31:0]        i_wdata,
   input  decode_pkg::instr_u i_instr,
   output logic [31:0]        o_rs_data,
   output logic [31:0]        o_rt_data
);

   logic [31:0] regs [32];
   logic        rs_hit;
   logic        rt_hit;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int k = 0; k < 32; k++) begin
            regs[k] <= '0;
         end
      end else if (i_we) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   // Write-through so decode sees the write-back value
   assign rs_hit = i_we && (i_waddr == i_instr.r.rs);
   assign rt_hit = i_we && (i_waddr == i_instr.r.rt);

   assign o_rs_data = rs_hit ? i_wdata : regs[i_instr.r.rs];
   assign o_rt_data = rt_hit ? i_wdata : regs[i_instr.r.rt];

endmodule

/* logic/decode_ctrl_if.sv */
interface decode_ctrl_if;
   logic       use_func_table;
   logic [3:0] alu_code;
   logic       b_i;
   logic       s_u_ex;
   logic       use_shamt;
   logic       mem_re;
   logic       mem_we;
   logic       s_u_mem;
   logic [1:0] dsize;
   logic       reg_we;
   logic       mem_alu;
   logic       data_pc;
   logic       to_ra;
   logic       is_branch;
   logic       bne;
   logic       jump_inm;
   logic       jump_rs;

   modport decoder (
      output use_func_table, alu_code, b_i, s_u_ex, use_shamt, mem_re, mem_we,
             s_u_mem, dsize, reg_we, mem_alu, data_pc, to_ra, is_branch, bne,
             jump_inm, jump_rs
   );

   modport resolver (input is_branch, bne, jump_inm, jump_rs, use_func_table);

   modport stage (
      input use_func_table, alu_code, b_i, s_u_ex, use_shamt, mem_re, mem_we,
            s_u_mem, dsize, reg_we, mem_alu, data_pc, to_ra, is_branch, bne,
            jump_inm, jump_rs
   );
endinterface

/* logic/decode_pkg.sv */
package decode_pkg;

   //////////////////////////////////////////////////
   // Instruction word
   //////////////////////////////////////////////////

   // One 32-bit word, three formats
   typedef union packed {
      struct packed {
         logic [5:0] opcode;
         logic [4:0] rs;
         logic [4:0] rt;
         logic [4:0] rd;
         logic [4:0] shamt;
         logic [5:0] func;
      } r;
      struct packed {
         logic [5:0]  opcode;
         logic [4:0]  rs;
         logic [4:0]  rt;
         logic [15:0] imm16;
      } i;
      struct packed {
         logic [5:0]  opcode;
         logic [25:0] target26;
      } j;
   } instr_u;

   //////////////////////////////////////////////////
   // Opcodes
   //////////////////////////////////////////////////

   localparam logic [5:0] R_INST = 6'b000000;
   localparam logic [5:0] LB     = 6'b100000;
   localparam logic [5:0] LH     = 6'b100001;
   localparam logic [5:0] LW     = 6'b100011;
   localparam logic [5:0] LBU    = 6'b100100;
   localparam logic [5:0] LHU    = 6'b100101;
   localparam logic [5:0] LWU    = 6'b100111;
   localparam logic [5:0] SB     = 6'b101000;
   localparam logic [5:0] SH     = 6'b101001;
   localparam logic [5:0] SW     = 6'b101011;
   localparam logic [5:0] ADDI   = 6'b001001;
   localparam logic [5:0] ANDI   = 6'b001100;
   localparam logic [5:0] ORI    = 6'b001101;
   localparam logic [5:0] XORI   = 6'b001110;
   localparam logic [5:0] LUI    = 6'b001111;
   localparam logic [5:0] SLTI   = 6'b001010;
   localparam logic [5:0] BEQ    = 6'b000100;
   localparam logic [5:0] BNE    = 6'b000101;
   localparam logic [5:0] J      = 6'b000010;
   localparam logic [5:0] JAL    = 6'b000011;

   // Function field of R-type words
   localparam logic [5:0] FUNC_SLL  = 6'b000000;
   localparam logic [5:0] FUNC_SRL  = 6'b000010;
   localparam logic [5:0] FUNC_SRA  = 6'b000011;
   localparam logic [5:0] FUNC_SLLV = 6'b000100;
   localparam logic [5:0] FUNC_SRLV = 6'b000110;
   localparam logic [5:0] FUNC_SRAV = 6'b000111;
   localparam logic [5:0] FUNC_ADDU = 6'b100001;
   localparam logic [5:0] FUNC_SUBU = 6'b100011;
   localparam logic [5:0] FUNC_AND  = 6'b100100;
   localparam logic [5:0] FUNC_OR   = 6'b100101;
   localparam logic [5:0] FUNC_XOR  = 6'b100110;
   localparam logic [5:0] FUNC_NOR  = 6'b100111;
   localparam logic [5:0] FUNC_SLT  = 6'b101010;
   localparam logic [5:0] FUNC_JR   = 6'b001000;
   localparam logic [5:0] FUNC_JALR = 6'b001001;

   //////////////////////////////////////////////////
   // ALU codes and frames
   //////////////////////////////////////////////////

   localparam logic [3:0] ALU_ADD = 4'b0000;
   localparam logic [3:0] ALU_SUB = 4'b0001;
   localparam logic [3:0] ALU_AND = 4'b0010;
   localparam logic [3:0] ALU_OR  = 4'b0011;
   localparam logic [3:0] ALU_XOR = 4'b0100;
   localparam logic [3:0] ALU_NOR = 4'b0101;
   localparam logic [3:0] ALU_SRL = 4'b0110;
   localparam logic [3:0] ALU_SLL = 4'b0111;
   localparam logic [3:0] ALU_SRA = 4'b1000;
   localparam logic [3:0] ALU_SLT = 4'b1010;
   localparam logic [3:0] ALU_LUI = 4'b1011;

   // EX {alu, b/i, s/u, shamt}, MEM {re, we, s/u, size}, WB {dest, we, mem/alu, data/pc}
   localparam int NB_EX  = 7;
   localparam int NB_MEM = 5;
   localparam int NB_WB  = 8;

   localparam logic [4:0] RA_ADDR = 5'd31;

endpackage
